/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // ======================================================================
    // Widths and sizes
    // ======================================================================
    localparam int DATA_W       = 4;
    localparam int PC_W         = 4;
    localparam int INSTR_W      = 16;
    localparam int REG_ADDR_W   = 3;
    localparam int NUM_REGS     = 8;
    localparam int IMEM_DEPTH   = 16;
    localparam int DMEM_DEPTH   = 16;
    localparam int STALL_CYCLES = 4;                     // Length of a hazard stall
    localparam int STALL_CNT_W  = $clog2(STALL_CYCLES);

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ======================================================================
    // Instruction set
    // ======================================================================
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        ADD   = 4'd1,   // rd = rs1 + rs2
        ADDI  = 4'd2,   // rd = rs1 + imm
        AND   = 4'd3,
        LOAD  = 4'd4,   // rd = mem[rs1 + imm]
        STORE = 4'd5,   // mem[rs1 + imm] = rs2
        XOR   = 4'd6,
        BEQ   = 4'd7,   // Absolute target when rs1 == rs2
        JUMP  = 4'd8
    } opcode_e;

    // Register and immediate layout
    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [2:0] imm;    // Zero-extended in ID
    } r_instr_t;

    // Branch and jump layout
    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [1:0] spare;
        pc_t        target;
    } b_instr_t;

    typedef union packed {
        r_instr_t r;
        b_instr_t b;
    } instr_u;

    // ======================================================================
    // Pipeline control
    // ======================================================================
    typedef enum logic [1:0] {
        RUN   = 2'd0,
        STALL = 2'd1,
        FLUSH = 2'd2,
        LOCK  = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire

/* common/id_ex_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Contents of the ID/EX register, moved on every unheld edge
interface id_ex_if import cpu_pkg::*; ();

    logic      valid;       // Slot holds a live instruction
    opcode_e   op;
    reg_addr_t rd;          // Zero when the op has no writeback
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     rs1_data;    // Register file values read in ID
    data_t     rs2_data;
    data_t     imm;
    pc_t       target;

    modport decode (
        output valid, op, rd, rs1, rs2, rs1_data, rs2_data, imm, target
    );

    modport execute (
        input  valid, op, rd, rs1, rs2, rs1_data, rs2_data, imm, target
    );

endinterface

`default_nettype wire

/* ctrl/hold_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module hold_timer import cpu_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic i_start,
    output logic o_expired
);

    logic                   running;
    logic [STALL_CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
        end else if (i_start) begin
            running <= 1'b1;
            count   <= STALL_CNT_W'(STALL_CYCLES - 1);
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;            // Expiry shown for one cycle
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_expired = running && count == '0;

    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        i_start |-> !running)
        else $error("stall timer restarted while counting");

endmodule

`default_nettype wire

/* ctrl/pipe_ctrl_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_fsm import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_hazard,
    input  logic        i_flush_req,
    input  logic        i_lock_req,
    input  logic        i_unlock_req,
    input  logic        i_auth_valid,
    output logic        o_hold,
    output logic        o_flush,
    output ctrl_state_e o_state
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        timer_start;
    logic        timer_expired;

    hold_timer i_timer (
        .clk       (clk),
        .reset     (reset),
        .i_start   (timer_start),
        .o_expired (timer_expired)
    );

    // Lock, then flush, then hazard
    always_comb begin
        state_nxt   = state;
        timer_start = 1'b0;
        if (state == LOCK) begin
            if (i_unlock_req && i_auth_valid) begin
                state_nxt = RUN;            // Unlock needs the auth strobe
            end
        end else if (i_lock_req) begin
            state_nxt = LOCK;
        end else if (i_flush_req) begin
            state_nxt = FLUSH;
        end else begin
            case (state)
                RUN: begin
                    if (i_hazard) begin
                        state_nxt   = STALL;
                        timer_start = 1'b1;
                    end
                end
                STALL:   if (timer_expired) state_nxt = RUN;
                default: state_nxt = RUN;   // FLUSH lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= RUN;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_hold  = state == STALL;
    assign o_flush = state == FLUSH || state == LOCK;   // LOCK keeps the pipe empty
    assign o_state = state;

    a_hold_flush_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(o_hold && o_flush))
        else $error("hold and flush together");

endmodule

`default_nettype wire

/* core/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_we,
    input  reg_addr_t i_waddr,
    input  data_t     i_wdata,
    input  reg_addr_t i_raddr1,
    input  reg_addr_t i_raddr2,
    output data_t     o_rdata1,
    output data_t     o_rdata2
);

    data_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    function automatic data_t read_port(reg_addr_t addr);
        data_t val;
        if (addr == '0) begin
            val = '0;                   // r0 is hard-wired
        end else if (i_we && addr == i_waddr) begin
            val = i_wdata;              // Write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        o_rdata1 = read_port(i_raddr1);
        o_rdata2 = read_port(i_raddr2);
    end

endmodule

`default_nettype wire

/* core/fetch_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_decode import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_hold,
    input  logic      i_flush,
    input  logic      i_redirect_valid,
    input  pc_t       i_redirect_pc,
    input  logic      i_imem_we,
    input  pc_t       i_imem_addr,
    input  instr_u    i_imem_data,
    output reg_addr_t o_rs1_addr,
    output reg_addr_t o_rs2_addr,
    input  data_t     i_rs1_data,
    input  data_t     i_rs2_data,
    output pc_t       o_pc,
    id_ex_if.decode   o_id_ex
);

    pc_t                pc;
    logic [INSTR_W-1:0] imem [IMEM_DEPTH];
    logic               if_id_valid;
    instr_u             if_id_instr;

    opcode_e   id_op;
    reg_addr_t id_rd;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    data_t     id_imm;

    // ======================================================================
    // IF stage
    // ======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (i_flush) begin
            pc <= '0;
        end else if (!i_hold) begin
            pc <= i_redirect_valid ? i_redirect_pc : pc + 1'b1;   // Wraps past 15
        end
    end

    // Program is written through this port, in any state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < IMEM_DEPTH; i++) begin
                imem[i] <= '0;
            end
        end else if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id_valid <= 1'b0;
        end else if (i_flush) begin
            if_id_valid <= 1'b0;
        end else if (!i_hold) begin
            if_id_valid <= !i_redirect_valid;   // Word fetched behind a redirect dies
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            if_id_instr <= imem[pc];
        end
    end

    // ======================================================================
    // ID stage
    // ======================================================================
    always_comb begin
        id_op  = NOP;
        id_rd  = '0;
        id_rs1 = '0;
        id_rs2 = '0;
        id_imm = '0;
        case (if_id_instr.r.opcode)
            ADD, AND, XOR: begin
                id_op  = if_id_instr.r.opcode;
                id_rd  = if_id_instr.r.rd;
                id_rs1 = if_id_instr.r.rs1;
                id_rs2 = if_id_instr.r.rs2;
            end
            ADDI, LOAD: begin
                id_op  = if_id_instr.r.opcode;
                id_rd  = if_id_instr.r.rd;
                id_rs1 = if_id_instr.r.rs1;
                id_imm = data_t'(if_id_instr.r.imm);
            end
            STORE: begin
                id_op  = STORE;
                id_rs1 = if_id_instr.r.rs1;
                id_rs2 = if_id_instr.r.rs2;    // Store data
                id_imm = data_t'(if_id_instr.r.imm);
            end
            BEQ: begin
                id_op  = BEQ;
                id_rs1 = if_id_instr.b.rs1;
                id_rs2 = if_id_instr.b.rs2;
            end
            JUMP:    id_op = JUMP;
            default: id_op = NOP;              // Unused opcodes
        endcase
    end

    assign o_rs1_addr = id_rs1;
    assign o_rs2_addr = id_rs2;
    assign o_pc       = pc;

    // ID/EX register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_id_ex.valid <= 1'b0;
        end else if (i_flush) begin
            o_id_ex.valid <= 1'b0;
        end else if (!i_hold) begin
            o_id_ex.valid <= if_id_valid && !i_redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_id_ex.op       <= id_op;
            o_id_ex.rd       <= id_rd;
            o_id_ex.rs1      <= id_rs1;
            o_id_ex.rs2      <= id_rs2;
            o_id_ex.rs1_data <= i_rs1_data;
            o_id_ex.rs2_data <= i_rs2_data;
            o_id_ex.imm      <= id_imm;
            o_id_ex.target   <= if_id_instr.b.target;
        end
    end

    // Slot squashed by a redirect must be dead when EX sees it
    a_no_redirect_from_squashed: assert property (@(posedge clk) disable iff (reset)
        i_redirect_valid |=> !o_id_ex.valid && !i_redirect_valid)
        else $error("redirect from a squashed ID/EX slot");

endmodule

`default_nettype wire

/* core/execute_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_mem import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_hold,
    input  logic      i_flush,
    id_ex_if.execute  i_id_ex,
    output logic      o_redirect_valid,
    output pc_t       o_redirect_pc,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_addr,
    output data_t     o_wb_data
);

    logic      advance;         // Stage registers move and side effects commit
    data_t     op_a;
    data_t     op_b;
    data_t     alu_out;
    logic      taken;

    logic      ex_mem_wr;
    logic      ex_mem_store;
    logic      ex_mem_load;
    reg_addr_t ex_mem_rd;
    data_t     ex_mem_result;   // ALU result or memory address
    data_t     ex_mem_sdata;
    data_t     mem_result;
    data_t     dmem [DMEM_DEPTH];

    logic      mem_wb_wr;
    reg_addr_t mem_wb_rd;
    data_t     mem_wb_data;

    assign advance = !i_hold && !i_flush;

    // Youngest producer wins
    function automatic data_t fwd(reg_addr_t src, data_t rf_data);
        data_t val;
        val = rf_data;
        if (src != '0 && ex_mem_wr && ex_mem_rd == src) begin
            val = mem_result;                   // Covers load then use
        end else if (src != '0 && mem_wb_wr && mem_wb_rd == src) begin
            val = mem_wb_data;
        end
        return val;
    endfunction

    // ======================================================================
    // EX stage
    // ======================================================================
    always_comb begin
        op_a = fwd(i_id_ex.rs1, i_id_ex.rs1_data);
        op_b = fwd(i_id_ex.rs2, i_id_ex.rs2_data);
        case (i_id_ex.op)
            ADD:     alu_out = op_a + op_b;
            AND:     alu_out = op_a & op_b;
            XOR:     alu_out = op_a ^ op_b;
            default: alu_out = op_a + i_id_ex.imm;  // ADDI, load/store address
        endcase
    end

    // Branches predicted not taken, resolved here
    assign taken = i_id_ex.valid &&
                   (i_id_ex.op == JUMP || (i_id_ex.op == BEQ && op_a == op_b));
    assign o_redirect_valid = taken && advance;
    assign o_redirect_pc    = i_id_ex.target;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem_wr    <= 1'b0;
            ex_mem_store <= 1'b0;
        end else if (i_flush) begin
            ex_mem_wr    <= 1'b0;
            ex_mem_store <= 1'b0;
        end else if (!i_hold) begin
            ex_mem_wr    <= i_id_ex.valid && i_id_ex.rd != '0;
            ex_mem_store <= i_id_ex.valid && i_id_ex.op == STORE;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            ex_mem_load   <= i_id_ex.op == LOAD;
            ex_mem_rd     <= i_id_ex.rd;
            ex_mem_result <= alu_out;
            ex_mem_sdata  <= op_b;
        end
    end

    // ======================================================================
    // MEM stage
    // ======================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_store && advance) begin
            dmem[ex_mem_result] <= ex_mem_sdata;
        end
    end

    assign mem_result = ex_mem_load ? dmem[ex_mem_result] : ex_mem_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb_wr <= 1'b0;
        end else if (i_flush) begin
            mem_wb_wr <= 1'b0;
        end else if (!i_hold) begin
            mem_wb_wr <= ex_mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            mem_wb_rd   <= ex_mem_rd;
            mem_wb_data <= mem_result;
        end
    end

    // WB, one strobe per instruction even across a stall
    assign o_wb_valid = mem_wb_wr && advance;
    assign o_wb_addr  = mem_wb_rd;
    assign o_wb_data  = mem_wb_data;

    // Decode zeroes rd for ops without a result, three stages earlier
    a_no_wb_to_r0: assert property (@(posedge clk) disable iff (reset)
        o_wb_valid |-> o_wb_addr != '0)
        else $error("writeback to register 0");

endmodule

`default_nettype wire

/* design/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_imem_we,
    input  pc_t         i_imem_addr,
    input  instr_u      i_imem_data,
    input  logic        i_hazard,
    input  logic        i_flush_req,
    input  logic        i_lock_req,
    input  logic        i_unlock_req,
    input  logic        i_auth_valid,
    output pc_t         o_pc,
    output ctrl_state_e o_state,
    output logic        o_wb_valid,
    output reg_addr_t   o_wb_addr,
    output data_t       o_wb_data
);

    logic      hold;
    logic      flush;
    logic      redirect_valid;
    pc_t       redirect_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1_data;
    data_t     rs2_data;

    id_ex_if id_ex ();

    // ======================================================================
    // Control
    // ======================================================================
    pipe_ctrl_fsm i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .i_hazard     (i_hazard),
        .i_flush_req  (i_flush_req),
        .i_lock_req   (i_lock_req),
        .i_unlock_req (i_unlock_req),
        .i_auth_valid (i_auth_valid),
        .o_hold       (hold),
        .o_flush      (flush),
        .o_state      (o_state)
    );

    // ======================================================================
    // Core
    // ======================================================================
    fetch_decode i_fetch (
        .clk              (clk),
        .reset            (reset),
        .i_hold           (hold),
        .i_flush          (flush),
        .i_redirect_valid (redirect_valid),
        .i_redirect_pc    (redirect_pc),
        .i_imem_we        (i_imem_we),
        .i_imem_addr      (i_imem_addr),
        .i_imem_data      (i_imem_data),
        .o_rs1_addr       (rs1_addr),
        .o_rs2_addr       (rs2_addr),
        .i_rs1_data       (rs1_data),
        .i_rs2_data       (rs2_data),
        .o_pc             (o_pc),
        .o_id_ex          (id_ex.decode)
    );

    execute_mem i_exec (
        .clk              (clk),
        .reset            (reset),
        .i_hold           (hold),
        .i_flush          (flush),
        .i_id_ex          (id_ex.execute),
        .o_redirect_valid (redirect_valid),
        .o_redirect_pc    (redirect_pc),
        .o_wb_valid       (o_wb_valid),
        .o_wb_addr        (o_wb_addr),
        .o_wb_data        (o_wb_data)
    );

    register_file i_regfile (
        .clk      (clk),
        .reset    (reset),
        .i_we     (o_wb_valid),     // Already qualified by hold and flush
        .i_waddr  (o_wb_addr),
        .i_wdata  (o_wb_data),
        .i_raddr1 (rs1_addr),
        .i_raddr2 (rs2_addr),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data)
    );

endmodule

`default_nettype wire

/* testbench/tb_isa_model.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// ======================================================================
// Architectural model of the 4-bit ISA
// ======================================================================
localparam int MODEL_STEP_LIMIT = 64;   // Program must reach its halt loop by then

logic [15:0] model_imem [16];
logic [3:0]  model_regs [8];
logic [3:0]  model_dmem [16];
logic [2:0]  exp_addr_q [$];            // Expected writebacks, oldest first
logic [3:0]  exp_data_q [$];

function automatic void clear_model_state();
    for (int i = 0; i < 16; i++) begin
        model_imem[i] = '0;
        model_dmem[i] = '0;
    end
    for (int i = 0; i < 8; i++) begin
        model_regs[i] = '0;
    end
    exp_addr_q.delete();
    exp_data_q.delete();
endfunction

// Runs from address 0 until a jump to itself, queueing every register write
function automatic bit predict_writebacks();
    logic [3:0]  pc;
    logic [3:0]  next_pc;
    logic [15:0] w;
    logic [3:0]  src_a;
    logic [3:0]  src_b;
    logic [3:0]  imm;
    logic [3:0]  addr;
    logic [3:0]  result;
    logic        writes;
    pc = 4'd0;
    for (int n = 0; n < MODEL_STEP_LIMIT; n++) begin
        w       = model_imem[pc];
        imm     = {1'b0, w[2:0]};               // Zero-extended
        src_a   = model_regs[w[8:6]];
        src_b   = model_regs[w[5:3]];
        addr    = src_a + imm;
        result  = 4'd0;
        writes  = 1'b0;
        next_pc = pc + 4'd1;
        case (w[15:12])
            ADD: begin
                result = src_a + src_b;
                writes = 1'b1;
            end
            ADDI: begin
                result = src_a + imm;
                writes = 1'b1;
            end
            AND: begin
                result = src_a & src_b;
                writes = 1'b1;
            end
            XOR: begin
                result = src_a ^ src_b;
                writes = 1'b1;
            end
            LOAD: begin
                result = model_dmem[addr];
                writes = 1'b1;
            end
            STORE: model_dmem[addr] = src_b;
            BEQ: begin
                if (model_regs[w[11:9]] == model_regs[w[8:6]]) begin
                    next_pc = w[3:0];           // Branch layout sources
                end
            end
            JUMP: begin
                if (w[3:0] == pc) begin
                    return 1'b1;                // Halt loop reached
                end
                next_pc = w[3:0];
            end
            default: ;                          // NOP and unused opcodes
        endcase
        if (writes && w[11:9] != 3'd0) begin
            model_regs[w[11:9]] = result;
            exp_addr_q.push_back(w[11:9]);
            exp_data_q.push_back(result);
        end
        pc = next_pc;
    end
    return 1'b0;
endfunction

`endif

/* testbench/tb_cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_LIMIT  = 200;
    localparam int QUIET_CYCLES = 12;   // Halt loop cycles watched for stray writebacks

    typedef enum logic [2:0] {
        ACT_LOAD, ACT_LOCK, ACT_UNLOCK, ACT_UNLOCK_NOAUTH,
        ACT_FLUSH, ACT_HAZARD, ACT_RUN, ACT_DRAIN
    } act_e;

    typedef struct packed {
        act_e        act;
        logic [7:0]  arg;               // Address, cycle count or hazard delay
        logic [15:0] word;
        ctrl_state_e exp_state;
        logic        chk_pc;
        pc_t         exp_pc;
    } row_t;

    logic        clk;
    logic        reset;
    logic        imem_we;
    pc_t         imem_addr;
    logic [15:0] imem_data;
    logic        hazard;
    logic        flush_req;
    logic        lock_req;
    logic        unlock_req;
    logic        auth_valid;
    pc_t         pc;
    ctrl_state_e state;
    logic        wb_valid;
    reg_addr_t   wb_addr;
    data_t       wb_data;

    row_t        rows [$];
    logic [15:0] program_words [16];
    int          stall_len;
    int          stall_runs;
    int unsigned seed_dummy;

    `include "tb_isa_model.svh"

    cpu_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .i_imem_we    (imem_we),
        .i_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .i_hazard     (hazard),
        .i_flush_req  (flush_req),
        .i_lock_req   (lock_req),
        .i_unlock_req (unlock_req),
        .i_auth_valid (auth_valid),
        .o_pc         (pc),
        .o_state      (state),
        .o_wb_valid   (wb_valid),
        .o_wb_addr    (wb_addr),
        .o_wb_data    (wb_data)
    );

    always #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [15:0] reg_format(input logic [3:0] op, input logic [2:0] rd,
                                               input logic [2:0] rs1, input logic [2:0] rs2,
                                               input logic [2:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [15:0] branch_format(input logic [3:0] op, input logic [2:0] rs1,
                                                  input logic [2:0] rs2, input logic [3:0] target);
        return {op, rs1, rs2, 2'b00, target};
    endfunction

    task automatic add_row(input act_e act, input int arg, input logic [15:0] word,
                           input ctrl_state_e exp_state, input logic chk_pc, input pc_t exp_pc);
        row_t r;
        r.act       = act;
        r.arg       = arg[7:0];
        r.word      = word;
        r.exp_state = exp_state;
        r.chk_pc    = chk_pc;
        r.exp_pc    = exp_pc;
        rows.push_back(r);
    endtask

    // ======================================================================
    // Program and stimulus table
    // ======================================================================
    task automatic build_table();
        program_words[0]  = reg_format(ADDI, 3'd1, 3'd1, 3'd0, 3'd5);  // Accumulates on rerun
        program_words[1]  = reg_format(ADDI, 3'd2, 3'd1, 3'd0, 3'd3);  // Back-to-back use
        program_words[2]  = reg_format(ADD, 3'd3, 3'd1, 3'd2, 3'd0);
        program_words[3]  = reg_format(STORE, 3'd0, 3'd0, 3'd3, 3'd2);
        program_words[4]  = reg_format(LOAD, 3'd4, 3'd0, 3'd0, 3'd2);
        program_words[5]  = reg_format(XOR, 3'd5, 3'd4, 3'd1, 3'd0);   // Load then use
        program_words[6]  = reg_format(AND, 3'd6, 3'd5, 3'd3, 3'd0);
        program_words[7]  = branch_format(BEQ, 3'd5, 3'd6, 4'd9);      // Taken on first run
        program_words[8]  = reg_format(ADDI, 3'd7, 3'd0, 3'd0, 3'd7);
        program_words[9]  = branch_format(BEQ, 3'd1, 3'd2, 4'd11);     // Not taken
        program_words[10] = 16'h0000;
        program_words[11] = reg_format(ADD, 3'd7, 3'd6, 3'd4, 3'd0);
        program_words[12] = reg_format(STORE, 3'd0, 3'd1, 3'd7, 3'd1);
        program_words[13] = reg_format(LOAD, 3'd2, 3'd1, 3'd0, 3'd1);
        program_words[14] = reg_format(4'hf, 3'd7, 3'd7, 3'd7, 3'd7);  // Unused opcode
        program_words[15] = branch_format(JUMP, 3'd0, 3'd0, 4'd15);    // Halt loop

        add_row(ACT_RUN, 0, '0, RUN, 1'b1, 4'd0);
        add_row(ACT_RUN, 12, '0, RUN, 1'b1, 4'd12);    // All-NOP memory
        add_row(ACT_LOCK, 0, '0, LOCK, 1'b0, 4'd0);
        for (int a = 0; a < 16; a++) begin
            add_row(ACT_LOAD, a, program_words[a], LOCK, 1'b1, 4'd0);
        end
        add_row(ACT_UNLOCK_NOAUTH, 0, '0, LOCK, 1'b1, 4'd0);
        add_row(ACT_UNLOCK, 0, '0, RUN, 1'b1, 4'd0);
        add_row(ACT_HAZARD, 1 + ($urandom % 12), '0, STALL, 1'b0, 4'd0);
        add_row(ACT_DRAIN, 0, '0, RUN, 1'b0, 4'd0);
        add_row(ACT_RUN, QUIET_CYCLES, '0, RUN, 1'b0, 4'd0);
        add_row(ACT_FLUSH, 0, '0, FLUSH, 1'b0, 4'd0);
        add_row(ACT_RUN, 1, '0, RUN, 1'b1, 4'd0);      // Flush lasts one cycle
        add_row(ACT_DRAIN, 0, '0, RUN, 1'b0, 4'd0);
        add_row(ACT_RUN, QUIET_CYCLES, '0, RUN, 1'b0, 4'd0);
    endtask

    task automatic run_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_row(input row_t r);
        bit halted;
        halted = 1'b1;
        case (r.act)
            ACT_LOAD: begin
                imem_we   = 1'b1;
                imem_addr = r.arg[3:0];
                imem_data = r.word;
                run_cycles(1);
                imem_we   = 1'b0;
                model_imem[r.arg[3:0]] = r.word;
            end
            ACT_LOCK: begin
                lock_req = 1'b1;
                run_cycles(1);
                lock_req = 1'b0;
            end
            ACT_UNLOCK, ACT_UNLOCK_NOAUTH: begin
                unlock_req = 1'b1;
                auth_valid = r.act == ACT_UNLOCK;
                run_cycles(1);
                unlock_req = 1'b0;
                auth_valid = 1'b0;
                if (r.act == ACT_UNLOCK) begin
                    halted = predict_writebacks();
                end
            end
            ACT_FLUSH: begin
                flush_req = 1'b1;
                run_cycles(1);
                flush_req = 1'b0;
                halted    = predict_writebacks();     // Rerun from the current state
            end
            ACT_HAZARD: begin
                run_cycles(r.arg);
                hazard = 1'b1;
                run_cycles(1);
                hazard = 1'b0;
            end
            ACT_DRAIN: begin
                for (int i = 0; i < DRAIN_LIMIT && exp_addr_q.size() != 0; i++) begin
                    @(negedge clk);
                end
                assert (exp_addr_q.size() == 0)
                    else report_failure("timeout while waiting for the expected writebacks");
            end
            default: run_cycles(r.arg);
        endcase
        assert (halted) else report_failure("model did not reach the halt loop");
        assert (state === r.exp_state)
            else report_failure($sformatf("mismatch o_state: expected %h, got %h",
                                          r.exp_state, state));
        if (r.chk_pc) begin
            assert (pc === r.exp_pc)
                else report_failure($sformatf("mismatch o_pc: expected %h, got %h",
                                              r.exp_pc, pc));
        end
    endtask

    // ======================================================================
    // Writeback and stall monitor
    // ======================================================================
    always @(negedge clk) begin
        if (!reset) begin
            if (wb_valid) begin
                assert (exp_addr_q.size() != 0)
                    else report_failure($sformatf("unexpected writeback to r%0d, data %h",
                                                  wb_addr, wb_data));
                assert (wb_addr === exp_addr_q[0])
                    else report_failure($sformatf("mismatch o_wb_addr: expected %h, got %h",
                                                  exp_addr_q[0], wb_addr));
                assert (wb_data === exp_data_q[0])
                    else report_failure($sformatf("mismatch o_wb_data: expected %h, got %h",
                                                  exp_data_q[0], wb_data));
                exp_addr_q.delete(0);
                exp_data_q.delete(0);
            end
            if (state == STALL) begin
                stall_len++;
                assert (!wb_valid) else report_failure("writeback seen during a stall");
            end else if (stall_len != 0) begin
                assert (stall_len == STALL_CYCLES)
                    else report_failure($sformatf("mismatch stall cycles: expected %h, got %h",
                                                  STALL_CYCLES, stall_len));
                stall_runs++;
                stall_len = 0;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_data  = '0;
        hazard     = 1'b0;
        flush_req  = 1'b0;
        lock_req   = 1'b0;
        unlock_req = 1'b0;
        auth_valid = 1'b0;
        stall_len  = 0;
        stall_runs = 0;
        seed_dummy = $urandom(32'h7d86_010b);
        clear_model_state();
        build_table();
        run_cycles(RESET_CYCLES);
        reset = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        assert (stall_runs == 1)
            else report_failure($sformatf("mismatch stall count: expected %h, got %h",
                                          1, stall_runs));
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+testbench
common/cpu_pkg.sv
common/id_ex_if.sv
ctrl/hold_timer.sv
ctrl/pipe_ctrl_fsm.sv
core/register_file.sv
core/fetch_decode.sv
core/execute_mem.sv
design/cpu_top.sv
testbench/tb_cpu_top.sv
